/* verilog/halfAccumPkg.sv */
`default_nettype none

package halfAccumPkg;

	// Half-precision field widths
	localparam int EXP_W = 5;
	localparam int MAN_W = 10;               // Stored mantissa, hidden bit not included
	localparam int HALF_W = 1 + EXP_W + MAN_W; // 16-bit word
	localparam int EXP_BIAS = 15;

	// Run geometry
	localparam int ELEM_COUNT = 8;            // Words summed per run
	localparam int ADDR_W = $clog2(ELEM_COUNT);

	// Hidden bit, mantissa, then guard, round and sticky
	localparam int SIG_W = 1 + MAN_W + 3;

	// Aligner in, rounder out
	localparam int ADD_LATENCY = 3;

	// Field view of a half word
	typedef struct packed {
		logic sign;
		logic [EXP_W-1:0] exponent;           // Zero reads as zero, no subnormals
		logic [MAN_W-1:0] mantissa;
	} halfFields;

	// One memory word, seen as bits or as fields
	typedef union packed {
		logic [HALF_W-1:0] raw;
		halfFields f;
	} halfWord;

	// Align stage to add stage
	typedef struct packed {
		logic valid;
		logic sign;                           // Sign of the larger magnitude
		logic effSub;                         // Operand signs differ
		logic [EXP_W-1:0] exponent;           // Common exponent
		logic [SIG_W-1:0] sigBig;
		logic [SIG_W-1:0] sigSmall;           // Already shifted, sticky in bit 0
	} alignedPair;

	// Fetched operand or adder result
	typedef struct packed {
		logic valid;
		halfWord word;
	} halfItem;

endpackage

`default_nettype wire

/* verilog/elementFetch.sv */
`timescale 1ns/1ps
`default_nettype none

module elementFetch (
	input logic ap_clk,
	input logic ap_rst,
	input logic runStart,                     // Rewinds to element 0
	input logic fetchReq,                     // One pulse per element
	output logic [halfAccumPkg::ADDR_W-1:0] memAddr,
	output logic memCe,
	input halfAccumPkg::halfWord memData,     // Arrives the cycle after memCe
	output halfAccumPkg::halfItem operand,
	output logic lastElem
);
	import halfAccumPkg::*;

	// Spare top bit lets the index reach ELEM_COUNT after the final read
	logic [ADDR_W:0] elemIdx;
	logic readValid;

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			elemIdx <= '0;
		end else if (runStart) begin
			elemIdx <= '0;
		end else if (fetchReq) begin
			elemIdx <= elemIdx + 1'b1; // Step after each read
		end
	end

	// Read data lands one cycle after the enable
	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			readValid <= 1'b0;
		end else begin
			readValid <= memCe;
		end
	end

	assign memCe = fetchReq;
	assign memAddr = elemIdx[ADDR_W-1:0];

	// All words issued, so the next adder result is the final sum
	assign lastElem = (elemIdx == (ADDR_W + 1)'(ELEM_COUNT));

	// Data taken straight off the memory port in its valid cycle
	assign operand = '{valid: readValid, word: memData};

	// Controller must stop requesting once every element has gone out
	fetchInRange: assert property (@(posedge ap_clk) disable iff (ap_rst)
		memCe |-> (elemIdx < (ADDR_W + 1)'(ELEM_COUNT)))
		else $error("memCe with element index %0d out of range", elemIdx);

endmodule

`default_nettype wire

/* verilog/halfAlign.sv */
`timescale 1ns/1ps
`default_nettype none

module halfAlign (
	input logic ap_clk,
	input logic ap_rst,
	input halfAccumPkg::halfItem opA,         // New element
	input halfAccumPkg::halfWord opB,         // Running sum
	output halfAccumPkg::alignedPair pair
);
	import halfAccumPkg::*;

	logic aIsBig;
	halfWord bigOp;
	halfWord smallOp;
	logic [EXP_W-1:0] expDiff;
	logic [SIG_W-1:0] sigBig;
	logic [SIG_W-1:0] sigSmall;
	logic [2*SIG_W-1:0] shiftWide;            // Upper half kept, lower half lost
	logic stickyBit;
	logic [SIG_W-1:0] sigAligned;

	// Exponent over mantissa, so the raw bits order by magnitude
	assign aIsBig = opA.word.raw[HALF_W-2:0] >= opB.raw[HALF_W-2:0];
	assign bigOp = aIsBig ? opA.word : opB;
	assign smallOp = aIsBig ? opB : opA.word;

	// Zero exponent reads as zero, otherwise the hidden bit comes back
	assign sigBig = (|bigOp.f.exponent) ?
		{1'b1, bigOp.f.mantissa, {(SIG_W - MAN_W - 1){1'b0}}} : '0;
	assign sigSmall = (|smallOp.f.exponent) ?
		{1'b1, smallOp.f.mantissa, {(SIG_W - MAN_W - 1){1'b0}}} : '0;

	// Never negative, big exponent is at least the small one
	assign expDiff = bigOp.f.exponent - smallOp.f.exponent;

	// Large differences push everything into the lower half
	assign shiftWide = {sigSmall, {SIG_W{1'b0}}} >> expDiff;
	assign stickyBit = |shiftWide[SIG_W-1:0];
	assign sigAligned = {shiftWide[2*SIG_W-1:SIG_W+1], shiftWide[SIG_W] | stickyBit};

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			pair.valid <= 1'b0;
		end else begin
			pair.valid <= opA.valid;
		end
		pair.sign <= bigOp.f.sign;
		pair.effSub <= opA.word.f.sign ^ opB.f.sign; // Differing signs subtract
		pair.exponent <= bigOp.f.exponent;
		pair.sigBig <= sigBig;
		pair.sigSmall <= sigAligned;
	end

endmodule

`default_nettype wire

/* verilog/halfAddNorm.sv */
`timescale 1ns/1ps
`default_nettype none

module halfAddNorm (
	input logic ap_clk,
	input logic ap_rst,
	input halfAccumPkg::alignedPair pair,
	output halfAccumPkg::halfItem result
);
	import halfAccumPkg::*;

	// Zeros above the leading one, all bits when the sum is zero
	function automatic logic [$clog2(SIG_W + 2)-1:0] leadZeros(input logic [SIG_W:0] value);
		logic [$clog2(SIG_W + 2)-1:0] count;
		logic found;
		count = '0;
		found = 1'b0;
		for (int i = SIG_W; i >= 0; i--) begin
			if (value[i]) begin
				found = 1'b1;
			end else if (!found) begin
				count = count + 1'b1;
			end
		end
		return count;
	endfunction

	// Add stage registers
	logic s2Valid;
	logic s2Sign;
	logic [EXP_W-1:0] s2Exp;
	logic [SIG_W:0] s2Sum;                    // Bit SIG_W catches the carry

	// Normalize and round
	logic [$clog2(SIG_W + 2)-1:0] lzCount;
	logic [SIG_W:0] normSum;
	logic [EXP_W+1:0] expNorm;                // Two's complement, may go negative
	logic [EXP_W+1:0] expRound;
	logic [MAN_W-1:0] manNorm;
	logic guardBit;
	logic stickyBit;
	logic roundUp;
	logic [MAN_W:0] manRound;
	halfWord resultWord;

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			s2Valid <= 1'b0;
		end else begin
			s2Valid <= pair.valid;
		end
		s2Sign <= pair.sign;
		s2Exp <= pair.exponent;
		// Larger significand first, so a difference stays non-negative
		if (pair.effSub) begin
			s2Sum <= {1'b0, pair.sigBig} - {1'b0, pair.sigSmall};
		end else begin
			s2Sum <= {1'b0, pair.sigBig} + {1'b0, pair.sigSmall};
		end
	end

	// Leading one moved to the top bit
	assign lzCount = leadZeros(s2Sum);
	assign normSum = s2Sum << lzCount;
	assign expNorm = {2'b00, s2Exp} + (EXP_W + 2)'(1) - (EXP_W + 2)'(lzCount); // Carry is +1

	assign manNorm = normSum[SIG_W-1:SIG_W-MAN_W];
	assign guardBit = normSum[SIG_W-MAN_W-1];
	assign stickyBit = |normSum[SIG_W-MAN_W-2:0];

	// Nearest even
	assign roundUp = guardBit & (stickyBit | manNorm[0]);
	assign manRound = {1'b0, manNorm} + (MAN_W + 1)'(roundUp);
	assign expRound = expNorm + (EXP_W + 2)'(manRound[MAN_W]); // Mantissa wrapped to zero

	always_comb begin
		resultWord.f.sign = s2Sign;
		resultWord.f.exponent = expRound[EXP_W-1:0];
		resultWord.f.mantissa = manRound[MAN_W-1:0];
		if (s2Sum == '0) begin
			resultWord.raw = '0; // Exact cancellation gives +0
		end else if (expRound[EXP_W+1] || expRound == '0) begin
			resultWord.f.exponent = '0; // Underflow, signed zero
			resultWord.f.mantissa = '0;
		end else if (expRound[EXP_W:0] >= (EXP_W + 1)'(2 * EXP_BIAS + 1)) begin
			resultWord.f.exponent = '1; // Saturate to infinity
			resultWord.f.mantissa = '0;
		end
	end

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			result.valid <= 1'b0;
		end else begin
			result.valid <= s2Valid;
		end
		result.word <= resultWord;
	end

	// Aligner hands over the larger significand first
	sigOrder: assert property (@(posedge ap_clk) disable iff (ap_rst)
		pair.valid |-> (pair.sigBig >= pair.sigSmall))
		else $error("Aligned significands out of order");

endmodule

`default_nettype wire

/* verilog/accumControl.sv */
`timescale 1ns/1ps
`default_nettype none

module accumControl (
	input logic ap_clk,
	input logic ap_rst,
	input logic ap_start,
	input logic ap_continue,
	output logic ap_done,
	output logic ap_idle,
	output logic ap_ready,
	output logic runStart,
	output logic fetchReq,
	input logic lastElem,                     // Every element already requested
	input halfAccumPkg::halfItem addResult,
	output halfAccumPkg::halfItem runningSum,
	output halfAccumPkg::halfWord sumOut,     // Held until the next completion
	output logic sumValid
);

	typedef enum logic [1:0] {
		stIdle,
		stFetch,                              // Request one element
		stWait,                               // Read plus adder latency
		stHold                                // Completion cycle
	} runState;

	runState state;
	runState nextState;
	logic doneHeld;                           // Done waiting for continue
	logic sumLoad;

	// Start refused while an earlier done is unacknowledged
	assign runStart = (state == stIdle) && ap_start && !doneHeld;
	assign fetchReq = (state == stFetch);
	assign sumLoad = (state == stWait) && addResult.valid;

	always_comb begin
		nextState = state;
		case (state)
			stIdle: begin
				if (runStart) begin
					nextState = stFetch;
				end
			end
			stFetch: nextState = stWait;
			stWait: begin
				if (sumLoad) begin
					nextState = lastElem ? stHold : stFetch; // Feedback, one in flight
				end
			end
			stHold: nextState = stIdle;
			default: nextState = stIdle;
		endcase
	end

	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			state <= stIdle;
		end else begin
			state <= nextState;
		end
	end

	// Sum register feeds the adder back
	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			runningSum.valid <= 1'b0;
		end else if (runStart) begin
			runningSum.valid <= 1'b1;
		end else if (sumLoad && lastElem) begin
			runningSum.valid <= 1'b0; // Run over
		end
		if (runStart) begin
			runningSum.word <= '0; // Positive zero
		end else if (sumLoad) begin
			runningSum.word <= addResult.word;
		end
	end

	// Final sum straight from the adder
	always_ff @(posedge ap_clk) begin
		if (sumLoad && lastElem) begin
			sumOut <= addResult.word;
		end
	end

	// Continue wins over a new completion
	always_ff @(posedge ap_clk) begin
		if (ap_rst) begin
			doneHeld <= 1'b0;
		end else if (ap_continue) begin
			doneHeld <= 1'b0;
		end else if (state == stHold) begin
			doneHeld <= 1'b1;
		end
	end

	assign ap_done = (state == stHold) || doneHeld;
	assign ap_ready = (state == stHold);
	assign sumValid = (state == stHold);
	assign ap_idle = (state == stIdle) && !ap_start;

	// One element in flight, so a sum only lands while waiting
	resultInWait: assert property (@(posedge ap_clk) disable iff (ap_rst)
		addResult.valid |-> (state == stWait))
		else $error("Adder result outside the wait state");

endmodule

`default_nettype wire

/* verilog/halfAccumTop.sv */
`timescale 1ns/1ps
`default_nettype none

module halfAccumTop (
	input logic ap_clk,
	input logic ap_rst,
	input logic ap_start,
	input logic ap_continue,
	output logic ap_done,
	output logic ap_idle,
	output logic ap_ready,
	output logic [halfAccumPkg::ADDR_W-1:0] memAddr,
	output logic memCe,
	input halfAccumPkg::halfWord memData,
	output halfAccumPkg::halfWord sumOut,
	output logic sumValid
);
	import halfAccumPkg::*;

	logic runStart;
	logic fetchReq;
	logic lastElem;
	halfItem operand;
	halfItem adderIn;
	halfItem addResult;
	halfItem runningSum;
	alignedPair pair;

	// Operand only counts inside an active run
	assign adderIn = '{valid: operand.valid & runningSum.valid, word: operand.word};

	elementFetch fetch (
		.ap_clk(ap_clk), .ap_rst(ap_rst),
		.runStart(runStart), .fetchReq(fetchReq),
		.memAddr(memAddr), .memCe(memCe), .memData(memData),
		.operand(operand), .lastElem(lastElem)
	);

	halfAlign align (
		.ap_clk(ap_clk), .ap_rst(ap_rst),
		.opA(adderIn), .opB(runningSum.word), .pair(pair)
	);

	halfAddNorm addNorm (
		.ap_clk(ap_clk), .ap_rst(ap_rst),
		.pair(pair), .result(addResult)
	);

	accumControl control (
		.ap_clk(ap_clk), .ap_rst(ap_rst),
		.ap_start(ap_start), .ap_continue(ap_continue),
		.ap_done(ap_done), .ap_idle(ap_idle), .ap_ready(ap_ready),
		.runStart(runStart), .fetchReq(fetchReq), .lastElem(lastElem),
		.addResult(addResult), .runningSum(runningSum),
		.sumOut(sumOut), .sumValid(sumValid)
	);

endmodule

`default_nettype wire

/* include/halfModel.svh */
`ifndef HALF_MODEL_SVH
`define HALF_MODEL_SVH

// Exact sum in integers, then one rounding to an 11-bit significand
function automatic logic [15:0] halfModelAdd(input logic [15:0] a, input logic [15:0] b);
	longint magA;
	longint magB;
	longint total;
	longint rest;
	longint half;
	int expA;
	int expB;
	int expMin;
	int msb;
	int shift;
	int expOut;
	logic signOut;
	expA = int'(a[14:10]);
	expB = int'(b[14:10]);
	magA = (expA == 0) ? 0 : longint'({1'b1, a[9:0]}); // Zero exponent reads as zero
	magB = (expB == 0) ? 0 : longint'({1'b1, b[9:0]});
	expMin = (expA < expB) ? expA : expB;
	magA = magA <<< (expA - expMin); // Common scale of the smaller exponent
	magB = magB <<< (expB - expMin);
	total = (a[15] ? -magA : magA) + (b[15] ? -magB : magB);
	if (total == 0) begin
		return 16'h0000; // Cancellation is +0
	end
	signOut = (total < 0);
	total = signOut ? -total : total;
	msb = 0;
	for (int i = 0; i < 48; i++) begin
		if (total[i]) begin
			msb = i;
		end
	end
	expOut = expMin + msb - 10;
	if (msb > 10) begin
		shift = msb - 10;
		rest = total & ((longint'(1) <<< shift) - 1);
		half = longint'(1) <<< (shift - 1);
		total = total >>> shift;
		if (rest > half || (rest == half && total[0])) begin
			total = total + 1; // Ties to even
		end
		if (total == 2048) begin
			total = total >>> 1;
			expOut = expOut + 1;
		end
	end else begin
		total = total <<< (10 - msb);
	end
	if (expOut <= 0) begin
		return {signOut, 15'd0}; // Flush, sign kept
	end
	if (expOut >= 31) begin
		return {signOut, 5'h1f, 10'd0};
	end
	return {signOut, 5'(expOut), total[9:0]};
endfunction

// Fold in index order from +0, as the hardware does
function automatic logic [15:0] halfModelSum(input logic [15:0] words [8]);
	logic [15:0] acc;
	acc = 16'h0000;
	for (int i = 0; i < 8; i++) begin
		acc = halfModelAdd(acc, words[i]);
	end
	return acc;
endfunction

`endif

/* testbench/halfAccumTb.sv */
`timescale 1ns/1ps
`default_nettype none

module halfAccumTb;
	import halfAccumPkg::*;

	logic ap_clk;
	logic ap_rst;
	logic ap_start;
	logic ap_continue;
	logic ap_done;
	logic ap_idle;
	logic ap_ready;
	logic [ADDR_W-1:0] memAddr;
	logic memCe;
	halfWord memData;
	halfWord sumOut;
	logic sumValid;

	logic [15:0] mem [8];                     // Eight-entry operand memory
	logic [15:0] runWords [8];
	logic [31:0] lfsrState;

	`include "halfModel.svh"

	halfAccumTop i_halfAccumTop (
		.ap_clk(ap_clk), .ap_rst(ap_rst),
		.ap_start(ap_start), .ap_continue(ap_continue),
		.ap_done(ap_done), .ap_idle(ap_idle), .ap_ready(ap_ready),
		.memAddr(memAddr), .memCe(memCe), .memData(memData),
		.sumOut(sumOut), .sumValid(sumValid)
	);

	initial begin
		ap_clk = 1'b0;
		forever #2 ap_clk = ~ap_clk;          // 4 ns period
	end

	// One-cycle read latency
	always @(posedge ap_clk) begin
		if (memCe) begin
			memData.raw <= mem[memAddr];
		end
	end

	task automatic checkEqual(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
			$display("=== FAIL ===");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic timeoutFail(input string what);
		$display("Timed out at %0t ns while waiting for %s", $time, what);
		$display("=== FAIL ===");
		$fatal(1, "Stopped on timeout");
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic takeBits(input int count, output logic [15:0] bits);
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrNext(lfsrState); // One step per bit
			bits = {bits[14:0], lfsrState[0]};
		end
	endtask

	// Normal operand, exponent 10..19, so eight of them stay far from overflow
	task automatic randomHalf(output logic [15:0] value);
		logic [15:0] signBit;
		logic [15:0] expPick;
		logic [15:0] manBits;
		takeBits(1, signBit);
		takeBits(4, expPick);
		takeBits(10, manBits);
		value = {signBit[0], 5'(10 + expPick % 10), manBits[9:0]};
	endtask

	// One full run; holdCycles of zero keeps continue high through completion
	task automatic runOnce(input logic [15:0] words [8], input int holdCycles,
		input logic pokeStart);
		logic [15:0] expected;
		int cycles;
		int addrSeen;
		int idleWait;
		expected = halfModelSum(words);
		for (int i = 0; i < 8; i++) begin
			mem[i] = words[i];
		end
		idleWait = 0;
		while (!ap_idle) begin
			@(negedge ap_clk);
			idleWait++;
			if (idleWait > 20) begin
				timeoutFail("ap_idle before start");
			end
		end
		@(posedge ap_clk);
		ap_start <= 1'b1;
		ap_continue <= (holdCycles == 0);
		cycles = 0;                           // Next cycle is the start cycle
		addrSeen = 0;
		do begin
			@(posedge ap_clk);
			ap_start <= 1'b0;
			cycles++;
			@(negedge ap_clk);
			if (memCe) begin
				checkEqual("memAddr", memAddr, addrSeen); // 0..7 in order
				addrSeen++;
			end
			if (!ap_done) begin
				checkEqual("ap_ready before done", ap_ready, 1'b0);
				checkEqual("sumValid before done", sumValid, 1'b0);
			end
			if (cycles > 60) begin
				timeoutFail("ap_done");
			end
		end while (!ap_done);
		checkEqual("ap_ready at done", ap_ready, 1'b1);
		checkEqual("sumValid at done", sumValid, 1'b1);
		checkEqual("sumOut", sumOut.raw, expected);
		// Request, read, then the adder for every element
		checkEqual("cycles from start to done", cycles, ELEM_COUNT * (2 + ADD_LATENCY) + 1);
		checkEqual("reads per run", addrSeen, 8);
		for (int h = 0; h < holdCycles; h++) begin
			@(posedge ap_clk);
			ap_start <= pokeStart;             // Must be refused while done held
			@(negedge ap_clk);
			checkEqual("ap_done held", ap_done, 1'b1);
			checkEqual("ap_ready after completion", ap_ready, 1'b0);
			checkEqual("sumValid after completion", sumValid, 1'b0);
			checkEqual("memCe while done held", memCe, 1'b0);
			checkEqual("sumOut held", sumOut.raw, expected);
		end
		if (holdCycles > 0) begin
			@(posedge ap_clk);
			ap_start <= 1'b0;
			ap_continue <= 1'b1;
			@(negedge ap_clk);
			checkEqual("memCe in continue cycle", memCe, 1'b0);
		end
		@(posedge ap_clk);
		ap_continue <= 1'b0;
		@(negedge ap_clk);
		checkEqual("ap_done after continue", ap_done, 1'b0);
		checkEqual("memCe after continue", memCe, 1'b0);
		checkEqual("ap_idle after continue", ap_idle, 1'b1);
		checkEqual("sumOut after continue", sumOut.raw, expected);
	endtask

	initial begin
		lfsrState = 32'hdb137d74;
		ap_rst = 1'b1;
		ap_start = 1'b0;
		ap_continue = 1'b0;
		memData.raw = '0;
		repeat (3) @(posedge ap_clk);
		ap_rst <= 1'b0;
		@(negedge ap_clk);
		checkEqual("ap_done after reset", ap_done, 1'b0);
		checkEqual("ap_ready after reset", ap_ready, 1'b0);
		checkEqual("sumValid after reset", sumValid, 1'b0);
		checkEqual("memCe after reset", memCe, 1'b0);
		checkEqual("ap_idle after reset", ap_idle, 1'b1);

		// Pairs that cancel exactly
		runWords = '{16'h3c00, 16'hbc00, 16'h4500, 16'hc500,
			16'h3555, 16'hb555, 16'h2e66, 16'hae66};
		checkEqual("model cancel", halfModelSum(runWords), 16'h0000);
		runOnce(runWords, 3, 1'b1);
		// 1.0 plus half an ulp, ties stay on the even mantissa
		runWords = '{16'h3c00, 16'h1000, 16'h1000, 16'h1000,
			16'h1000, 16'h1000, 16'h1000, 16'h1000};
		checkEqual("model tie even", halfModelSum(runWords), 16'h3c00);
		runOnce(runWords, 0, 1'b0);
		runWords[0] = 16'h3c01;               // Odd start rounds up once
		checkEqual("model tie odd", halfModelSum(runWords), 16'h3c02);
		runOnce(runWords, 2, 1'b1);

		for (int run = 0; run < 30; run++) begin
			for (int i = 0; i < 8; i++) begin
				randomHalf(runWords[i]);
			end
			runOnce(runWords, run % 4, run[0]);
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* halfAccumTop.f */
+incdir+include
verilog/halfAccumPkg.sv
verilog/elementFetch.sv
verilog/halfAlign.sv
verilog/halfAddNorm.sv
verilog/accumControl.sv
verilog/halfAccumTop.sv
testbench/halfAccumTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Verilator build and run of the half-precision accumulator testbench
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module halfAccumTb \
	-f halfAccumTop.f -o halfAccumSim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/halfAccumSim > sim.log 2>&1
cat sim.log
! grep -q "=== FAIL ===" sim.log && grep -q "=== PASS ===" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
